// ==== project.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_ifs.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/reg_file.sv
src/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

    localparam int IMEM_AW    = $clog2(`CPU_IMEM_WORDS);
    localparam int START_WORD = `CPU_START_PC / `CPU_INST_SIZE;
    localparam int WAIT_LIMIT = 200;
    localparam logic [`CPU_DBITS-1:0] HEX_ADDR  = `CPU_ADDR_HEX;
    localparam logic [`CPU_DBITS-1:0] LEDR_ADDR = `CPU_ADDR_LEDR;
    localparam logic [7:0] ALU_OPS [14] = '{
        `CPU_OP2_EQ, `CPU_OP2_LT, `CPU_OP2_LE, `CPU_OP2_NE, `CPU_OP2_ADD,
        `CPU_OP2_AND, `CPU_OP2_OR, `CPU_OP2_XOR, `CPU_OP2_SUB, `CPU_OP2_NAND,
        `CPU_OP2_NOR, `CPU_OP2_NXOR, `CPU_OP2_RSHF, `CPU_OP2_LSHF
    };

    logic                           clk;
    logic                           reset;
    logic                           load_we;
    logic [IMEM_AW-1:0]             load_addr;
    logic [`CPU_DBITS-1:0]          load_data;
    logic [`CPU_HEX_BITS-1:0]       hex;
    logic [`CPU_LEDR_BITS-1:0]      ledr;
    isa_pkg::instr_t                prog [$];
    int                             seed;

    cpu_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .hex       (hex),
        .ledr      (ledr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Bound PC properties count their failures
    always @(posedge clk) begin
        if (i_dut.i_fetch.i_props.fail_count != 0) begin
            fail_now("A fetch PC assertion failed");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;   // Drive and sample away from the edge
    endtask

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic [`CPU_DBITS-1:0] sext16(input logic [15:0] v);
        return {{(`CPU_DBITS-16){v[15]}}, v};
    endfunction

    function automatic isa_pkg::instr_t alu_reg(input logic [7:0] op2, input isa_pkg::regno_t rd,
                                                input isa_pkg::regno_t rs,
                                                input isa_pkg::regno_t rt);
        isa_pkg::instr_t w;
        w = '0;
        w.r.op1 = `CPU_OP1_ALUR;
        w.r.op2 = op2;
        w.r.rd  = rd;
        w.r.rs  = rs;
        w.r.rt  = rt;
        return w;
    endfunction

    function automatic isa_pkg::instr_t imm_form(input logic [5:0] op1, input isa_pkg::regno_t rt,
                                                 input isa_pkg::regno_t rs,
                                                 input logic [`CPU_IMM_BITS-1:0] imm);
        isa_pkg::instr_t w;
        w = '0;
        w.i.op1 = op1;
        w.i.imm = imm;
        w.i.rs  = rs;
        w.i.rt  = rt;
        return w;
    endfunction

    // I/O addresses fit a sign-extended offset from r0
    function automatic isa_pkg::instr_t store_word(input isa_pkg::regno_t rt,
                                                   input logic [`CPU_DBITS-1:0] addr);
        return imm_form(`CPU_OP1_SW, rt, 4'd0, addr[15:0]);
    endfunction

    function automatic logic [`CPU_DBITS-1:0] alu_model(input logic [7:0] op2,
                                                        input logic signed [`CPU_DBITS-1:0] a,
                                                        input logic signed [`CPU_DBITS-1:0] b);
        logic [`CPU_DBITS-1:0] r;
        case (op2)
            `CPU_OP2_EQ:   r = (a == b) ? 32'd1 : 32'd0;
            `CPU_OP2_LT:   r = (a < b) ? 32'd1 : 32'd0;
            `CPU_OP2_LE:   r = (a <= b) ? 32'd1 : 32'd0;
            `CPU_OP2_NE:   r = (a != b) ? 32'd1 : 32'd0;
            `CPU_OP2_ADD:  r = a + b;
            `CPU_OP2_AND:  r = a & b;
            `CPU_OP2_OR:   r = a | b;
            `CPU_OP2_XOR:  r = a ^ b;
            `CPU_OP2_SUB:  r = a - b;
            `CPU_OP2_NAND: r = ~(a & b);
            `CPU_OP2_NOR:  r = ~(a | b);
            `CPU_OP2_NXOR: r = ~(a ^ b);
            `CPU_OP2_RSHF: r = a >>> b[4:0];   // Amounts stay below 32
            `CPU_OP2_LSHF: r = a << b[4:0];
            default:       r = '0;
        endcase
        return r;
    endfunction

    task automatic check_hex(input logic [`CPU_HEX_BITS-1:0] exp,
                             input logic [`CPU_HEX_BITS-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("Fail at %0t ns: hex expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_ledr(input logic [`CPU_LEDR_BITS-1:0] exp,
                              input logic [`CPU_LEDR_BITS-1:0] act);
        if (act !== exp) begin
            fail_now($sformatf("Fail at %0t ns: ledr expected %h actual %h", $time, exp, act));
        end
    endtask

    // A store of the value already shown is invisible, so no wait then
    task automatic wait_hex(input logic [`CPU_HEX_BITS-1:0] exp);
        logic [`CPU_HEX_BITS-1:0] last;
        int n;
        last = hex;
        n = 0;
        if (exp != last) begin
            while (hex == last && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
        end
        if (exp != last && hex == last) begin
            fail_now("Timeout: hex never changed within 200 cycles");
        end else begin
            check_hex(exp, hex);
        end
    endtask

    task automatic wait_ledr(input logic [`CPU_LEDR_BITS-1:0] exp);
        logic [`CPU_LEDR_BITS-1:0] last;
        int n;
        last = ledr;
        n = 0;
        if (exp != last) begin
            while (ledr == last && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
        end
        if (exp != last && ledr == last) begin
            fail_now("Timeout: ledr never changed within 200 cycles");
        end else begin
            check_ledr(exp, ledr);
        end
    endtask

    task automatic hold_outputs(input logic [`CPU_HEX_BITS-1:0] exp_hex,
                                input logic [`CPU_LEDR_BITS-1:0] exp_ledr, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            next_cycle();
            check_hex(exp_hex, hex);
            check_ledr(exp_ledr, ledr);
        end
    endtask

    // Park on a self loop, pad past the fetch run-ahead, load under reset
    task automatic run_program();
        int i;
        prog.push_back(imm_form(`CPU_OP1_BEQ, 4'd0, 4'd0, 16'd0));
        prog.push_back('0);
        prog.push_back('0);
        next_cycle();
        reset = 1'b1;
        next_cycle();
        next_cycle();
        for (i = 0; i < prog.size(); i++) begin
            load_we   = 1'b1;
            load_addr = IMEM_AW'(START_WORD + i);
            load_data = prog[i];
            next_cycle();
        end
        load_we = 1'b0;
        reset   = 1'b0;
    endtask

    task automatic test_reset_values();
        prog.delete();
        run_program();
        hold_outputs(`CPU_HEX_RESET, '0, 10);
    endtask

    task automatic test_alu_chain();
        logic [15:0]           ia;
        logic [15:0]           ib;
        logic [`CPU_DBITS-1:0] b;
        logic [`CPU_DBITS-1:0] res;
        logic                  shift;
        int                    k;
        ia = rand16();
        ib = rand16();
        b  = sext16(ib);
        prog.delete();
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd1, 4'd0, ia));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd2, 4'd0, ib));
        prog.push_back(imm_form(`CPU_OP1_ANDI, 4'd4, 4'd2, 16'd31));   // Shift amount
        for (k = 0; k < 14; k++) begin
            shift = (ALU_OPS[k] == `CPU_OP2_RSHF) || (ALU_OPS[k] == `CPU_OP2_LSHF);
            prog.push_back(alu_reg(ALU_OPS[k], 4'd3, 4'd1, shift ? 4'd4 : 4'd2));
            prog.push_back(store_word(4'd3, HEX_ADDR));
        end
        run_program();
        for (k = 0; k < 14; k++) begin
            shift = (ALU_OPS[k] == `CPU_OP2_RSHF) || (ALU_OPS[k] == `CPU_OP2_LSHF);
            res   = alu_model(ALU_OPS[k], sext16(ia), shift ? (b & 32'd31) : b);
            wait_hex(res[`CPU_HEX_BITS-1:0]);
        end
    endtask

    task automatic test_imm_ops();
        logic [15:0]           ia;
        logic [15:0]           ix;
        logic [15:0]           iy;
        logic [15:0]           iz;
        logic [`CPU_DBITS-1:0] a;
        logic [`CPU_DBITS-1:0] res;
        ia = rand16();
        ix = rand16();
        iy = rand16();
        iz = rand16();
        a  = sext16(ia);
        prog.delete();
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd1, 4'd0, ia));
        prog.push_back(imm_form(`CPU_OP1_ANDI, 4'd2, 4'd1, ix));
        prog.push_back(store_word(4'd2, LEDR_ADDR));
        prog.push_back(imm_form(`CPU_OP1_ORI, 4'd3, 4'd1, iy));
        prog.push_back(store_word(4'd3, LEDR_ADDR));
        prog.push_back(imm_form(`CPU_OP1_XORI, 4'd5, 4'd1, iz));
        prog.push_back(store_word(4'd5, LEDR_ADDR));
        run_program();
        res = a & sext16(ix);
        wait_ledr(res[`CPU_LEDR_BITS-1:0]);
        res = a | sext16(iy);
        wait_ledr(res[`CPU_LEDR_BITS-1:0]);
        res = a ^ sext16(iz);
        wait_ledr(res[`CPU_LEDR_BITS-1:0]);
    endtask

    task automatic test_memory();
        logic [15:0]           va;
        logic [15:0]           vb;
        logic [`CPU_DBITS-1:0] sum;
        va  = rand16();
        vb  = rand16();
        sum = sext16(va) + sext16(vb);
        prog.delete();
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd1, 4'd0, va));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd2, 4'd0, vb));
        prog.push_back(imm_form(`CPU_OP1_SW, 4'd1, 4'd0, 16'h0040));
        prog.push_back(imm_form(`CPU_OP1_SW, 4'd2, 4'd0, 16'h0044));
        prog.push_back(imm_form(`CPU_OP1_LW, 4'd3, 4'd0, 16'h0040));
        prog.push_back(imm_form(`CPU_OP1_LW, 4'd4, 4'd0, 16'h0044));
        prog.push_back(alu_reg(`CPU_OP2_ADD, 4'd5, 4'd3, 4'd4));
        prog.push_back(store_word(4'd5, HEX_ADDR));
        run_program();
        wait_hex(sum[`CPU_HEX_BITS-1:0]);
    endtask

    // Taken branch hops over the wrong marker in r7 and the other falls into its marker
    task automatic branch_pair(input logic [5:0] op1, input isa_pkg::regno_t t_rs,
                               input isa_pkg::regno_t t_rt, input isa_pkg::regno_t f_rs,
                               input isa_pkg::regno_t f_rt, input isa_pkg::regno_t marker);
        prog.push_back(imm_form(op1, t_rt, t_rs, 16'd2));
        prog.push_back(store_word(4'd7, HEX_ADDR));
        prog.push_back(imm_form(op1, f_rt, f_rs, 16'd2));
        prog.push_back(store_word(marker, HEX_ADDR));
    endtask

    task automatic test_branches();
        logic [15:0] vn;
        logic [15:0] vp;
        vn = rand16() | 16'h8000;   // Negative
        vp = rand16() & 16'h7fff;
        prog.delete();
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd1, 4'd0, vn));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd2, 4'd0, vp));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd3, 4'd1, 16'd0));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd7, 4'd0, 16'h0bad));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd8, 4'd0, 16'h0c01));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd9, 4'd0, 16'h0c02));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd10, 4'd0, 16'h0c03));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd11, 4'd0, 16'h0c04));
        branch_pair(`CPU_OP1_BEQ, 4'd1, 4'd3, 4'd1, 4'd2, 4'd8);
        branch_pair(`CPU_OP1_BLT, 4'd1, 4'd2, 4'd2, 4'd1, 4'd9);
        branch_pair(`CPU_OP1_BLE, 4'd1, 4'd3, 4'd2, 4'd1, 4'd10);
        branch_pair(`CPU_OP1_BNE, 4'd1, 4'd2, 4'd1, 4'd3, 4'd11);
        run_program();
        wait_hex(24'h000c01);
        wait_hex(24'h000c02);
        wait_hex(24'h000c03);
        wait_hex(24'h000c04);
        hold_outputs(24'h000c04, '0, 20);
    endtask

    task automatic test_jal();
        logic [`CPU_DBITS-1:0] jal_addr;
        logic [`CPU_DBITS-1:0] dest;
        prog.delete();
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd5, 4'd0, 16'h0155));
        prog.push_back(imm_form(`CPU_OP1_ADDI, 4'd4, 4'd0, 16'h02aa));
        prog.push_back(store_word(4'd5, LEDR_ADDR));
        jal_addr = `CPU_START_PC + `CPU_INST_SIZE * prog.size();
        dest     = jal_addr + 32'd12;
        prog.push_back(imm_form(`CPU_OP1_JAL, 4'd6, 4'd0, dest[17:2]));
        prog.push_back(store_word(4'd4, LEDR_ADDR));   // Squashed
        prog.push_back(store_word(4'd4, LEDR_ADDR));   // Squashed
        prog.push_back(store_word(4'd6, HEX_ADDR));
        run_program();
        wait_ledr(10'h155);
        dest = jal_addr + `CPU_INST_SIZE;
        wait_hex(dest[`CPU_HEX_BITS-1:0]);
        hold_outputs(dest[`CPU_HEX_BITS-1:0], 10'h155, 20);
    endtask

    initial begin
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 32'h33475eb4;
        test_reset_values();
        test_alu_chain();
        test_imm_ops();
        test_memory();
        test_branches();
        test_jal();
        if (i_dut.i_fetch.i_props.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_now("A fetch PC assertion failed");
        end
    end

endmodule

// ==== test/cpu_props.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     stall,
    input logic                     redirect,
    input logic [`CPU_DBITS-1:0]    target,
    input logic [`CPU_DBITS-1:0]    pc
);

    int fail_count = 0;   // Watched by the testbench

    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
    else begin
        $error("PC %h is not word aligned", pc);
        fail_count++;
    end

    // A stall freezes the PC unless a redirect overrides it
    pc_holds: assert property (@(posedge clk) disable iff (reset)
        stall && !redirect |=> $stable(pc))
    else begin
        $error("PC moved during a stall");
        fail_count++;
    end

    pc_steps: assert property (@(posedge clk) disable iff (reset)
        !stall && !redirect |=> pc == $past(pc) + `CPU_INST_SIZE)
    else begin
        $error("PC did not advance by one instruction");
        fail_count++;
    end

    pc_jumps: assert property (@(posedge clk) disable iff (reset)
        redirect |=> pc == $past(target))
    else begin
        $error("PC did not load the redirect target");
        fail_count++;
    end

endmodule

bind fetch_unit cpu_props i_props (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
);

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load_we,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0]  load_addr,
    input  logic [`CPU_DBITS-1:0]               load_data,
    output logic [`CPU_HEX_BITS-1:0]            hex,
    output logic [`CPU_LEDR_BITS-1:0]           ledr
);

    isa_pkg::instr_t        fe_instr;
    logic [`CPU_DBITS-1:0]  fe_pc_next;
    logic                   stall;
    logic                   redirect;
    logic [`CPU_DBITS-1:0]  target;
    isa_pkg::regno_t        mem_dst;
    logic                   mem_reg_we;

    regfile_if rf_bus ();
    id_ex_if   id_ex ();
    ex_mem_if  ex_mem ();

    fetch_unit i_fetch (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .instr     (fe_instr),
        .pc_next   (fe_pc_next)
    );

    decode_stage i_decode (
        .clk        (clk),
        .reset      (reset),
        .instr      (fe_instr),
        .pc_next    (fe_pc_next),
        .rf         (rf_bus.decode),
        .redirect   (redirect),
        .mem_dst    (mem_dst),
        .mem_reg_we (mem_reg_we),
        .exm        (ex_mem.dst),      // Hazard view of the execute latch
        .out        (id_ex.src),
        .stall      (stall)
    );

    execute_stage i_execute (
        .clk      (clk),
        .reset    (reset),
        .in       (id_ex.dst),
        .out      (ex_mem.src),
        .redirect (redirect),
        .target   (target)
    );

    mem_stage i_mem (
        .clk        (clk),
        .reset      (reset),
        .in         (ex_mem.dst),
        .rf         (rf_bus.wb),
        .mem_dst    (mem_dst),
        .mem_reg_we (mem_reg_we),
        .hex        (hex),
        .ledr       (ledr)
    );

    reg_file i_rf (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_bus.rf)
    );

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_file (
    input  logic    clk,
    input  logic    reset,
    regfile_if.rf   rf
);

    localparam int NREGS = 1 << `CPU_REGNO_BITS;

    logic [`CPU_DBITS-1:0] regs [NREGS];

    // Write in the middle of the cycle so decode sees it before the next edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    assign rf.rs_val = regs[rf.rs];
    assign rf.rt_val = regs[rf.rt];

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_stage (
    input  logic                        clk,
    input  logic                        reset,
    ex_mem_if.dst                       in,
    regfile_if.wb                       rf,
    output isa_pkg::regno_t             mem_dst,
    output logic                        mem_reg_we,
    output logic [`CPU_HEX_BITS-1:0]    hex,
    output logic [`CPU_LEDR_BITS-1:0]   ledr
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_DBITS-1:0]  dmem [`CPU_DMEM_WORDS];
    logic [DMEM_AW-1:0]     widx;
    logic                   hit_hex;
    logic                   hit_ledr;
    logic [`CPU_DBITS-1:0]  load_val;
    logic [`CPU_DBITS-1:0]  wb_val;
    logic                   wb_reg_we;
    isa_pkg::regno_t        wb_dst;
    logic [`CPU_DBITS-1:0]  wb_data;

    assign widx     = in.alu_out[DMEM_AW+1:2];
    assign hit_hex  = (in.alu_out == `CPU_ADDR_HEX);
    assign hit_ledr = (in.alu_out == `CPU_ADDR_LEDR);
    assign load_val = dmem[widx];

    // I/O addresses alias low words, so keep them out of the RAM
    always_ff @(posedge clk) begin
        if (in.mem_we && !hit_hex && !hit_ledr) begin
            dmem[widx] <= in.store_val;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= `CPU_HEX_RESET;
            ledr <= '0;
        end else if (in.mem_we) begin
            if (hit_hex) begin
                hex <= in.store_val[`CPU_HEX_BITS-1:0];
            end
            if (hit_ledr) begin
                ledr <= in.store_val[`CPU_LEDR_BITS-1:0];
            end
        end
    end

    always_comb begin
        case (in.wb_sel)
            `CPU_WB_PC:  wb_val = in.pc_next;
            `CPU_WB_MEM: wb_val = load_val;
            default:     wb_val = in.alu_out;
        endcase
    end

    // Memory latch, feeds the falling-edge register write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_reg_we <= 1'b0;
        end else begin
            wb_reg_we <= in.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_dst  <= in.dst_reg;
        wb_data <= wb_val;
    end

    assign rf.we      = wb_reg_we;
    assign rf.waddr   = wb_dst;
    assign rf.wdata   = wb_data;
    assign mem_dst    = wb_dst;      // For the decode hazard check
    assign mem_reg_we = wb_reg_we;

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    id_ex_if.dst                    in,
    ex_mem_if.src                   out,
    output logic                    redirect,
    output logic [`CPU_DBITS-1:0]   target
);

    logic [5:0]                    op1;
    logic [7:0]                    op2;
    logic signed [`CPU_DBITS-1:0]  a;
    logic signed [`CPU_DBITS-1:0]  b;
    logic signed [`CPU_DBITS-1:0]  t;
    logic [`CPU_DBITS-1:0]         alu;
    logic [`CPU_DBITS-1:0]         offset;
    logic                          taken;
    logic                          is_jal;

    assign op1    = in.instr.r.op1;
    assign op2    = in.instr.r.op2;
    assign a      = in.rs_val;
    assign t      = in.rt_val;
    assign b      = (op1 == `CPU_OP1_ALUR) ? in.rt_val : in.imm;
    assign offset = in.imm << 2;          // Word offset to bytes

    always_comb begin
        alu = '0;
        if (op1 == `CPU_OP1_ALUR) begin
            case (op2)
                `CPU_OP2_EQ:   alu[0] = (a == b);
                `CPU_OP2_LT:   alu[0] = (a < b);
                `CPU_OP2_LE:   alu[0] = (a <= b);
                `CPU_OP2_NE:   alu[0] = (a != b);
                `CPU_OP2_ADD:  alu = a + b;
                `CPU_OP2_AND:  alu = a & b;
                `CPU_OP2_OR:   alu = a | b;
                `CPU_OP2_XOR:  alu = a ^ b;
                `CPU_OP2_SUB:  alu = a - b;
                `CPU_OP2_NAND: alu = ~(a & b);
                `CPU_OP2_NOR:  alu = ~(a | b);
                `CPU_OP2_NXOR: alu = ~(a ^ b);
                `CPU_OP2_RSHF: alu = a >>> b;   // Sign fill
                `CPU_OP2_LSHF: alu = a << b;
                default:       alu = '0;
            endcase
        end else begin
            case (op1)
                `CPU_OP1_ANDI: alu = a & b;
                `CPU_OP1_ORI:  alu = a | b;
                `CPU_OP1_XORI: alu = a ^ b;
                default:       alu = a + b;     // ADDI and LW/SW address
            endcase
        end
    end

    // Signed branch compare of rs against rt
    always_comb begin
        case (op1)
            `CPU_OP1_BEQ: taken = (a == t);
            `CPU_OP1_BLT: taken = (a < t);
            `CPU_OP1_BLE: taken = (a <= t);
            `CPU_OP1_BNE: taken = (a != t);
            default:      taken = 1'b0;
        endcase
    end

    assign is_jal   = (op1 == `CPU_OP1_JAL);
    assign redirect = taken || is_jal;
    assign target   = is_jal ? in.rs_val + offset
                             : in.pc_next - `CPU_INST_SIZE + offset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out.reg_we <= 1'b0;
            out.mem_we <= 1'b0;
        end else begin
            out.reg_we <= in.reg_we;
            out.mem_we <= in.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        out.alu_out   <= alu;
        out.store_val <= in.rt_val;
        out.pc_next   <= in.pc_next;   // Link value for JAL
        out.dst_reg   <= in.dst_reg;
        out.wb_sel    <= in.wb_sel;
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  isa_pkg::instr_t         instr,
    input  logic [`CPU_DBITS-1:0]   pc_next,
    regfile_if.decode               rf,
    input  logic                    redirect,
    input  isa_pkg::regno_t         mem_dst,
    input  logic                    mem_reg_we,
    ex_mem_if.dst                   exm,
    id_ex_if.src                    out,
    output logic                    stall
);

    logic                   reg_we;
    logic                   mem_we;
    logic [1:0]             wb_sel;
    logic                   dst_is_rd;
    logic                   uses_rt;
    logic [`CPU_DBITS-1:0]  imm_sx;
    isa_pkg::regno_t        dst;
    logic                   rs_busy;
    logic                   rt_busy;

    // True when register r is still to be written by an older instruction
    function automatic logic pending(isa_pkg::regno_t r, isa_pkg::regno_t d, logic we);
        return (r != '0) && we && (r == d);
    endfunction

    assign rf.rs = instr.r.rs;
    assign rf.rt = instr.r.rt;

    assign imm_sx = {{(`CPU_DBITS-`CPU_IMM_BITS){instr.i.imm[`CPU_IMM_BITS-1]}}, instr.i.imm};
    assign dst    = dst_is_rd ? instr.r.rd : instr.r.rt;

    always_comb begin
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        wb_sel    = `CPU_WB_ALU;
        dst_is_rd = 1'b0;
        uses_rt   = 1'b0;
        case (instr.r.op1)
            `CPU_OP1_ALUR: begin
                reg_we    = (instr.r.op2 != '0);   // All-zero word is a bubble
                dst_is_rd = 1'b1;
                uses_rt   = 1'b1;
            end
            `CPU_OP1_BEQ, `CPU_OP1_BLT, `CPU_OP1_BLE, `CPU_OP1_BNE: begin
                uses_rt = 1'b1;
            end
            `CPU_OP1_JAL: begin
                reg_we = 1'b1;
                wb_sel = `CPU_WB_PC;
            end
            `CPU_OP1_LW: begin
                reg_we = 1'b1;
                wb_sel = `CPU_WB_MEM;
            end
            `CPU_OP1_SW: begin
                mem_we  = 1'b1;
                uses_rt = 1'b1;
            end
            `CPU_OP1_ADDI, `CPU_OP1_ANDI, `CPU_OP1_ORI, `CPU_OP1_XORI: begin
                reg_we = 1'b1;
            end
            default: ;
        endcase
    end

    // Read-after-write check against decode, execute and memory latches
    assign rs_busy = pending(instr.r.rs, out.dst_reg, out.reg_we) ||
                     pending(instr.r.rs, exm.dst_reg, exm.reg_we) ||
                     pending(instr.r.rs, mem_dst, mem_reg_we);
    assign rt_busy = pending(instr.r.rt, out.dst_reg, out.reg_we) ||
                     pending(instr.r.rt, exm.dst_reg, exm.reg_we) ||
                     pending(instr.r.rt, mem_dst, mem_reg_we);
    assign stall   = rs_busy || (uses_rt && rt_busy);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out.instr  <= '0;
            out.reg_we <= 1'b0;
            out.mem_we <= 1'b0;
        end else if (stall || redirect) begin
            out.instr  <= '0;                      // Bubble
            out.reg_we <= 1'b0;
            out.mem_we <= 1'b0;
        end else begin
            out.instr  <= instr;
            out.reg_we <= reg_we;
            out.mem_we <= mem_we;
        end
    end

    // Operands and fields, don't care under a bubble
    always_ff @(posedge clk) begin
        out.rs_val  <= rf.rs_val;
        out.rt_val  <= rf.rt_val;
        out.imm     <= imm_sx;
        out.pc_next <= pc_next;
        out.dst_reg <= dst;
        out.wb_sel  <= wb_sel;
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load_we,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0]  load_addr,
    input  logic [`CPU_DBITS-1:0]               load_data,
    input  logic                                stall,
    input  logic                                redirect,
    input  logic [`CPU_DBITS-1:0]               target,
    output isa_pkg::instr_t                     instr,
    output logic [`CPU_DBITS-1:0]               pc_next
);

    localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

    logic [`CPU_DBITS-1:0] imem [`CPU_IMEM_WORDS];
    logic [`CPU_DBITS-1:0] pc;
    logic [`CPU_DBITS-1:0] pc_plus;
    logic [`CPU_DBITS-1:0] fetched;

    assign pc_plus = pc + `CPU_INST_SIZE;
    assign fetched = imem[pc[IMEM_AW+1:2]];   // Word index

    // Program load port
    always_ff @(posedge clk) begin
        if (load_we) begin
            imem[load_addr] <= load_data;
        end
    end

    // PC and fetch latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= `CPU_START_PC;
            instr   <= '0;
            pc_next <= '0;
        end else if (redirect) begin
            pc    <= target;
            instr <= '0;                     // Squash wrong-path fetch
        end else if (!stall) begin
            pc      <= pc_plus;
            instr   <= fetched;
            pc_next <= pc_plus;
        end
    end

endmodule

// ==== src/pipe_ifs.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

// Register file ports, read by decode and written from the memory latch
interface regfile_if;
    isa_pkg::regno_t        rs;
    isa_pkg::regno_t        rt;
    logic [`CPU_DBITS-1:0]  rs_val;
    logic [`CPU_DBITS-1:0]  rt_val;
    logic                   we;
    isa_pkg::regno_t        waddr;
    logic [`CPU_DBITS-1:0]  wdata;

    modport decode (output rs, output rt, input rs_val, input rt_val);
    modport wb     (output we, output waddr, output wdata);
    modport rf     (input rs, input rt, input we, input waddr, input wdata,
                    output rs_val, output rt_val);
endinterface

// Decode latch contents
interface id_ex_if;
    isa_pkg::instr_t        instr;
    logic [`CPU_DBITS-1:0]  rs_val;
    logic [`CPU_DBITS-1:0]  rt_val;
    logic [`CPU_DBITS-1:0]  imm;      // Sign extended
    logic [`CPU_DBITS-1:0]  pc_next;
    isa_pkg::regno_t        dst_reg;
    logic                   reg_we;
    logic                   mem_we;
    logic [1:0]             wb_sel;

    modport src (output instr, output rs_val, output rt_val, output imm, output pc_next,
                 output dst_reg, output reg_we, output mem_we, output wb_sel);
    modport dst (input instr, input rs_val, input rt_val, input imm, input pc_next,
                 input dst_reg, input reg_we, input mem_we, input wb_sel);
endinterface

// Execute latch contents
interface ex_mem_if;
    logic [`CPU_DBITS-1:0]  alu_out;
    logic [`CPU_DBITS-1:0]  store_val;
    logic [`CPU_DBITS-1:0]  pc_next;
    isa_pkg::regno_t        dst_reg;
    logic                   reg_we;
    logic                   mem_we;
    logic [1:0]             wb_sel;

    modport src (output alu_out, output store_val, output pc_next, output dst_reg,
                 output reg_we, output mem_we, output wb_sel);
    modport dst (input alu_out, input store_val, input pc_next, input dst_reg,
                 input reg_we, input mem_we, input wb_sel);
endinterface

// ==== src/isa_pkg.sv ====
`include "cpu_settings.svh"

package isa_pkg;

    typedef logic [`CPU_REGNO_BITS-1:0] regno_t;

    // Register form, ALUR only
    typedef struct packed {
        logic [5:0] op1;
        logic [7:0] op2;
        logic [5:0] unused;
        regno_t     rd;
        regno_t     rs;
        regno_t     rt;
    } rform_t;

    // Immediate form: branches, JAL, loads, stores, ALU immediates
    typedef struct packed {
        logic [5:0]               op1;
        logic [1:0]               unused;
        logic [`CPU_IMM_BITS-1:0] imm;
        regno_t                   rs;
        regno_t                   rt;
    } iform_t;

    typedef union packed {
        rform_t r;
        iform_t i;
    } instr_t;

endpackage

// ==== src/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath widths
`define CPU_DBITS       32
`define CPU_REGNO_BITS  4
`define CPU_IMM_BITS    16

`define CPU_START_PC    32'h100
`define CPU_INST_SIZE   32'd4
`define CPU_IMEM_WORDS  1024
`define CPU_DMEM_WORDS  1024

// Memory-mapped output registers
`define CPU_ADDR_HEX    32'hFFFFF000
`define CPU_ADDR_LEDR   32'hFFFFF020
`define CPU_HEX_RESET   24'hFEDEAD
`define CPU_HEX_BITS    24
`define CPU_LEDR_BITS   10

// Primary opcodes
`define CPU_OP1_ALUR    6'b000000
`define CPU_OP1_BEQ     6'b001000
`define CPU_OP1_BLT     6'b001001
`define CPU_OP1_BLE     6'b001010
`define CPU_OP1_BNE     6'b001011
`define CPU_OP1_JAL     6'b001100
`define CPU_OP1_LW      6'b010010
`define CPU_OP1_SW      6'b011010
`define CPU_OP1_ADDI    6'b100000
`define CPU_OP1_ANDI    6'b100100
`define CPU_OP1_ORI     6'b100101
`define CPU_OP1_XORI    6'b100110

// Secondary opcodes, ALUR only
`define CPU_OP2_EQ      8'b00001000
`define CPU_OP2_LT      8'b00001001
`define CPU_OP2_LE      8'b00001010
`define CPU_OP2_NE      8'b00001011
`define CPU_OP2_ADD     8'b00100000
`define CPU_OP2_AND     8'b00100100
`define CPU_OP2_OR      8'b00100101
`define CPU_OP2_XOR     8'b00100110
`define CPU_OP2_SUB     8'b00101000
`define CPU_OP2_NAND    8'b00101100
`define CPU_OP2_NOR     8'b00101101
`define CPU_OP2_NXOR    8'b00101110
`define CPU_OP2_RSHF    8'b00110000
`define CPU_OP2_LSHF    8'b00110001

// Write-back source select
`define CPU_WB_PC       2'b00
`define CPU_WB_MEM      2'b01
`define CPU_WB_ALU      2'b10

`endif
